// ==== hw/asg_burst_seq.sv ====
// trigger masking, run FSM, burst counters and trigger output
`timescale 1ns/100ps
`include "asg_defines.svh"

module asg_burst_seq (
  input  logic                 sto,
  input  logic                 ctl_rst,
  // trigger
  input  logic [`ASG_TN-1:0]   trg_i,
  input  logic [`ASG_TN-1:0]   cfg_trg,
  output logic                 trg_o,
  // burst config
  input  logic                 cfg_ben,
  input  logic                 cfg_inf,
  input  logic [`ASG_CWM-1:0]  cfg_bdl,
  input  logic [32-1:0]        cfg_bil,
  input  logic [16-1:0]        cfg_bnm,
  // to accumulator and table
  output asg_pkg::asg_state_t  seq_state,
  output logic                 seq_start
);

  // masked trigger and run events
  logic trg_any;
  logic trg_acc;
  logic brst_end;
  logic brst_rpt;

  // burst counters
  logic [`ASG_CWM-1:0] cnt_bdl;
  logic [32-1:0]       cnt_bil;
  logic [16-1:0]       cnt_bnm;

  ////////////////////////////////////////////////////////////
  // events
  ////////////////////////////////////////////////////////////

  // any enabled trigger line
  assign trg_any = |(trg_i & cfg_trg);
  // accepted only while idle
  assign trg_acc = trg_any & (seq_state == asg_pkg::st_idle);

  // data and gap both used up
  assign brst_end = cfg_ben & (seq_state != asg_pkg::st_idle) & ~|cnt_bdl & ~|cnt_bil;
  // another burst follows
  assign brst_rpt = brst_end & (cfg_inf | (cnt_bnm > 16'd1));

  assign seq_start = trg_acc | brst_rpt;

  ////////////////////////////////////////////////////////////
  // run FSM and counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      seq_state <= asg_pkg::st_idle;
      cnt_bdl   <= '0;
      cnt_bil   <= '0;
      cnt_bnm   <= '0;
    end else if (seq_start) begin
      // new burst, reload lengths
      seq_state <= asg_pkg::st_data;
      cnt_bdl   <= cfg_bdl;
      cnt_bil   <= cfg_bil;
      if (trg_acc) begin
        cnt_bnm <= cfg_bnm;
      end else if (|cnt_bnm) begin
        // infinite mode parks at zero
        cnt_bnm <= cnt_bnm - 16'd1;
      end
    end else if (brst_end) begin
      // last burst done
      seq_state <= asg_pkg::st_idle;
      cnt_bnm   <= '0;
    end else if (cfg_ben) begin
      if (seq_state == asg_pkg::st_data) begin
        if (|cnt_bdl) begin
          cnt_bdl <= cnt_bdl - 1'b1;
        end else begin
          // gap is nonzero here, else burst would have ended
          seq_state <= asg_pkg::st_delay;
        end
      end
      if ((seq_state == asg_pkg::st_delay) && |cnt_bil) begin
        cnt_bil <= cnt_bil - 32'd1;
      end
    end
  end

  // one pulse per burst start
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      trg_o <= 1'b0;
    end else begin
      trg_o <= seq_start;
    end
  end

endmodule

// ==== hw/asg_defines.svh ====
// pointer format, sample width and trigger count for the waveform channel
`ifndef ASG_DEFINES_SVH
`define ASG_DEFINES_SVH

////////////////////////////////////////////////////////////
// fixed-point read pointer
////////////////////////////////////////////////////////////

// integer bits of the pointer and the table address width
`define ASG_CWM 14
// fraction bits of the pointer
`define ASG_CWF 16
// full pointer width for size, step and offset
`define ASG_PW (`ASG_CWM + `ASG_CWF)

// sample width at the stream and CPU port
`define ASG_DW 14
// number of trigger inputs
`define ASG_TN 4

`endif

// ==== hw/asg_phase_acc.sv ====
// fixed-point read pointer with offset load and modulo wrap
`timescale 1ns/100ps
`include "asg_defines.svh"

module asg_phase_acc (
  input  logic                 sto,
  input  logic                 ctl_rst,
  // from sequencer
  input  logic                 seq_start,
  input  asg_pkg::asg_state_t  seq_state,
  // table length minus one, step and phase
  input  logic [`ASG_PW-1:0]   cfg_siz,
  input  logic [`ASG_PW-1:0]   cfg_stp,
  input  logic [`ASG_PW-1:0]   cfg_off,
  // current pointer
  output logic [`ASG_PW-1:0]   ptr
);

  // sum with carry
  logic [`ASG_PW:0]   ptr_sum;
  // sum minus table length with sign bit on top
  logic [`ASG_PW+1:0] ptr_dif;
  logic               ptr_neg;
  logic [`ASG_PW-1:0] ptr_nxt;

  ////////////////////////////////////////////////////////////
  // next pointer
  ////////////////////////////////////////////////////////////

  assign ptr_sum = {1'b0, ptr} + {1'b0, cfg_stp};
  assign ptr_dif = {1'b0, ptr_sum} - {2'b00, cfg_siz} - 1'b1;
  assign ptr_neg = ptr_dif[`ASG_PW+1];

  // negative means still inside the table
  assign ptr_nxt = ptr_neg ? ptr_sum[`ASG_PW-1:0] : ptr_dif[`ASG_PW-1:0];

  ////////////////////////////////////////////////////////////
  // pointer register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      ptr <= '0;
    end else if (seq_start) begin
      // phase set at every burst start
      ptr <= cfg_off;
    end else if (seq_state == asg_pkg::st_data) begin
      ptr <= ptr_nxt;
    end
  end

endmodule

// ==== hw/asg_pkg.sv ====
// sequencer state type and sample type shared by the channel
`include "asg_defines.svh"

package asg_pkg;

  ////////////////////////////////////////////////////////////
  // run state
  ////////////////////////////////////////////////////////////

  // idle waits for a trigger
  // data streams samples
  // delay is the gap after a burst
  typedef enum logic [1:0] {
    st_idle  = 2'b00,
    st_data  = 2'b01,
    st_delay = 2'b10
  } asg_state_t;

  ////////////////////////////////////////////////////////////
  // payload
  ////////////////////////////////////////////////////////////

  // one table entry or stream sample
  typedef logic [`ASG_DW-1:0] sample_t;

endpackage

// ==== hw/asg_table_out.sv ====
// sample table with CPU access and two-stage stream read
`timescale 1ns/100ps
`include "asg_defines.svh"

module asg_table_out (
  input  logic                 sto,
  input  logic                 ctl_rst,
  // read side control
  input  asg_pkg::asg_state_t  seq_state,
  input  logic [`ASG_PW-1:0]   ptr,
  // CPU port
  input  logic                 bus_wen,
  input  logic                 bus_ren,
  input  logic [`ASG_CWM-1:0]  bus_addr,
  input  asg_pkg::sample_t     bus_wdata,
  output asg_pkg::sample_t     bus_rdata,
  output logic                 bus_ack,
  // sample stream
  output logic                 sto_vld,
  output asg_pkg::sample_t     sto_dat
);

  // table storage
  asg_pkg::sample_t    tbl_mem [0:2**`ASG_CWM-1];

  // stream pipeline
  logic [`ASG_CWM-1:0] tbl_raddr;
  asg_pkg::asg_state_t state_d;

  ////////////////////////////////////////////////////////////
  // CPU side
  ////////////////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (bus_wen) begin
      tbl_mem[bus_addr] <= bus_wdata;
    end
  end

  // read-back lines up with ack
  always_ff @(posedge sto) begin
    if (bus_ren) begin
      bus_rdata <= tbl_mem[bus_addr];
    end
  end

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      bus_ack <= 1'b0;
    end else begin
      bus_ack <= bus_wen | bus_ren;
    end
  end

  ////////////////////////////////////////////////////////////
  // stream side
  ////////////////////////////////////////////////////////////

  // stage one, integer part of pointer
  always_ff @(posedge sto) begin
    if (seq_state == asg_pkg::st_data) begin
      tbl_raddr <= ptr[`ASG_CWF +: `ASG_CWM];
    end
  end

  // state follows the address stage
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      state_d <= asg_pkg::st_idle;
      sto_vld <= 1'b0;
    end else begin
      state_d <= seq_state;
      sto_vld <= (state_d == asg_pkg::st_data);
    end
  end

  // stage two reads the RAM and zeroes idle cycles
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      sto_dat <= '0;
    end else if (state_d == asg_pkg::st_data) begin
      sto_dat <= tbl_mem[tbl_raddr];
    end else begin
      sto_dat <= '0;
    end
  end

endmodule

// ==== hw/asg_top.sv ====
// one waveform channel: sequencer, phase accumulator and table
`timescale 1ns/100ps
`include "asg_defines.svh"

module asg_top (
  input  logic                 sto,
  input  logic                 ctl_rst,
  // trigger
  input  logic [`ASG_TN-1:0]   trg_i,
  output logic                 trg_o,
  // config
  input  logic [`ASG_TN-1:0]   cfg_trg,
  input  logic [`ASG_PW-1:0]   cfg_siz,
  input  logic [`ASG_PW-1:0]   cfg_stp,
  input  logic [`ASG_PW-1:0]   cfg_off,
  // burst config
  input  logic                 cfg_ben,
  input  logic                 cfg_inf,
  input  logic [`ASG_CWM-1:0]  cfg_bdl,
  input  logic [32-1:0]        cfg_bil,
  input  logic [16-1:0]        cfg_bnm,
  // CPU port
  input  logic                 bus_wen,
  input  logic                 bus_ren,
  input  logic [`ASG_CWM-1:0]  bus_addr,
  input  asg_pkg::sample_t     bus_wdata,
  output asg_pkg::sample_t     bus_rdata,
  output logic                 bus_ack,
  // sample stream
  output logic                 sto_vld,
  output asg_pkg::sample_t     sto_dat
);

  // stage links
  asg_pkg::asg_state_t seq_state;
  logic                seq_start;
  logic [`ASG_PW-1:0]  ptr;

  ////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////

  asg_burst_seq i_asg_burst_seq (
    .sto       (sto),
    .ctl_rst   (ctl_rst),
    .trg_i     (trg_i),
    .cfg_trg   (cfg_trg),
    .trg_o     (trg_o),
    .cfg_ben   (cfg_ben),
    .cfg_inf   (cfg_inf),
    .cfg_bdl   (cfg_bdl),
    .cfg_bil   (cfg_bil),
    .cfg_bnm   (cfg_bnm),
    .seq_state (seq_state),
    .seq_start (seq_start)
  );

  ////////////////////////////////////////////////////////////
  // execute
  ////////////////////////////////////////////////////////////

  asg_phase_acc i_asg_phase_acc (
    .sto       (sto),
    .ctl_rst   (ctl_rst),
    .seq_start (seq_start),
    .seq_state (seq_state),
    .cfg_siz   (cfg_siz),
    .cfg_stp   (cfg_stp),
    .cfg_off   (cfg_off),
    .ptr       (ptr)
  );

  ////////////////////////////////////////////////////////////
  // result
  ////////////////////////////////////////////////////////////

  asg_table_out i_asg_table_out (
    .sto       (sto),
    .ctl_rst   (ctl_rst),
    .seq_state (seq_state),
    .ptr       (ptr),
    .bus_wen   (bus_wen),
    .bus_ren   (bus_ren),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_rdata (bus_rdata),
    .bus_ack   (bus_ack),
    .sto_vld   (sto_vld),
    .sto_dat   (sto_dat)
  );

endmodule

// ==== sources.f ====
+incdir+hw
hw/asg_pkg.sv
hw/asg_burst_seq.sv
hw/asg_phase_acc.sv
hw/asg_table_out.sv
hw/asg_top.sv
verification/asg_props.sv
verification/asg_tb.sv

// ==== verification/asg_props.sv ====
// concurrent checks on CPU ack, stream zeroing, reset and trigger latency
`timescale 1ns/100ps
`include "asg_defines.svh"

module asg_props (
  input logic                sto,
  input logic                ctl_rst,
  input logic [`ASG_TN-1:0]  trg_i,
  input logic [`ASG_TN-1:0]  cfg_trg,
  input asg_pkg::asg_state_t seq_state,
  input logic                bus_wen,
  input logic                bus_ren,
  input logic                bus_ack,
  input logic                trg_o,
  input logic                sto_vld,
  input asg_pkg::sample_t    sto_dat
);

  // failures so far, summed up by the testbench
  int fail_cnt = 0;

  // trigger taken while idle
  logic trg_acc;

  assign trg_acc = |(trg_i & cfg_trg) && (seq_state == asg_pkg::st_idle);

  ////////////////////////////////////////////////////////////
  // CPU port and stream
  ////////////////////////////////////////////////////////////

  // ack one cycle after each strobe and at no other time
  ack_after_strobe: assert property (@(posedge sto) disable iff (ctl_rst)
      bus_ack == $past(bus_wen || bus_ren))
    else begin
      fail_cnt++;
      $error("bus_ack does not match the strobe of the previous cycle");
    end

  dat_zero_idle: assert property (@(posedge sto) disable iff (ctl_rst)
      !sto_vld |-> sto_dat == '0)
    else begin
      fail_cnt++;
      $error("sto_dat is not zero while sto_vld is low");
    end

  ////////////////////////////////////////////////////////////
  // reset and trigger timing
  ////////////////////////////////////////////////////////////

  rst_quiet: assert property (@(posedge sto)
      ctl_rst |=> !sto_vld && !trg_o)
    else begin
      fail_cnt++;
      $error("sto_vld or trg_o high in the cycle after reset");
    end

  // first sample two cycles after acceptance
  trg_to_vld: assert property (@(posedge sto) disable iff (ctl_rst)
      trg_acc |-> ##2 !sto_vld ##1 sto_vld)
    else begin
      fail_cnt++;
      $error("sto_vld did not rise two cycles after an accepted trigger");
    end

endmodule

// every channel instance gets the checks
bind asg_top asg_props i_asg_props (.*);

// ==== verification/asg_tb.sv ====
// channel testbench with table model, CPU port, continuous and burst stream checks
`timescale 1ns/100ps
`include "asg_defines.svh"

module asg_tb;

  // ramp table length for the stream tests
  localparam int TBL_N = 24;

  logic                 sto = 1'b0;
  logic                 ctl_rst = 1'b1;
  logic [`ASG_TN-1:0]   trg_i = '0;
  logic [`ASG_TN-1:0]   cfg_trg = 4'b0100;
  logic [`ASG_PW-1:0]   cfg_siz = '0;
  logic [`ASG_PW-1:0]   cfg_stp = '0;
  logic [`ASG_PW-1:0]   cfg_off = '0;
  logic                 cfg_ben = 1'b0;
  logic                 cfg_inf = 1'b0;
  logic [`ASG_CWM-1:0]  cfg_bdl = '0;
  logic [32-1:0]        cfg_bil = '0;
  logic [16-1:0]        cfg_bnm = '0;
  logic                 bus_wen = 1'b0;
  logic                 bus_ren = 1'b0;
  logic [`ASG_CWM-1:0]  bus_addr = '0;
  asg_pkg::sample_t     bus_wdata = '0;
  asg_pkg::sample_t     bus_rdata;
  logic                 bus_ack;
  logic                 trg_o;
  logic                 sto_vld;
  asg_pkg::sample_t     sto_dat;

  // reference table and expected pointer
  asg_pkg::sample_t     tbl_model [0:2**`ASG_CWM-1];
  logic [`ASG_PW-1:0]   ptr_exp;
  logic [`ASG_CWM-1:0]  addr_q [$];
  integer               seed = 32'h6e6;
  int                   err_cnt = 0;
  int                   tout_cnt = 0;

  asg_top i_asg_top (.*);

  always #4 sto = ~sto;

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  function automatic void compare_value(input string name, input int exp, input int act);
    assert (exp == act) else begin
      err_cnt++;
      $display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
    end
  endfunction

  // step added, wrapped by the table length once past cfg_siz
  function automatic logic [`ASG_PW-1:0] next_ptr(input logic [`ASG_PW-1:0] p);
    logic [`ASG_PW:0] sum;
    sum = p + cfg_stp;
    if (sum > cfg_siz) begin
      sum = sum - cfg_siz - 1;
    end
    return sum[`ASG_PW-1:0];
  endfunction

  task automatic reset_dut();
    @(negedge sto);
    ctl_rst = 1'b1;
    repeat (2) @(negedge sto);
    ctl_rst = 1'b0;
  endtask

  // one strobe, ack and read data due on the next cycle
  task automatic cpu_access(input logic wr, input logic [`ASG_CWM-1:0] addr,
                            input asg_pkg::sample_t data);
    bus_wen = wr;
    bus_ren = !wr;
    bus_addr = addr;
    bus_wdata = data;
    @(negedge sto);
    bus_wen = 1'b0;
    bus_ren = 1'b0;
    compare_value("bus_ack", 1, bus_ack);
    if (wr) begin
      tbl_model[addr] = data;
    end else begin
      compare_value("bus_rdata", tbl_model[addr], bus_rdata);
    end
  endtask

  // masked lines first, then a real trigger up to the first sample
  task automatic start_run(input int quiet);
    int n;
    trg_i = ~cfg_trg;
    repeat (quiet) begin
      @(negedge sto);
      compare_value("trg_o", 0, trg_o);
      compare_value("sto_vld", 0, sto_vld);
    end
    trg_i = cfg_trg;
    ptr_exp = cfg_off;
    @(negedge sto);
    trg_i = '0;
    compare_value("trg_o", 1, trg_o);
    n = 0;
    do begin
      @(negedge sto);
      n++;
    end while (!sto_vld && n < 16);
    if (!sto_vld) begin
      tout_cnt++;
      $display("timeout, no valid sample within 16 cycles of the trigger");
    end
    compare_value("sto_vld latency", 2, n);
  endtask

  // continuous stream against the model
  task automatic check_stream(input int count);
    for (int i = 0; i < count; i++) begin
      compare_value("sto_vld", 1, sto_vld);
      compare_value("sto_dat", tbl_model[ptr_exp[`ASG_CWF +: `ASG_CWM]], sto_dat);
      // no restart pulse while running
      compare_value("trg_o", 0, trg_o);
      ptr_exp = next_ptr(ptr_exp);
      // ignored while running
      trg_i = `ASG_TN'($random(seed));
      @(negedge sto);
    end
    trg_i = '0;
  endtask

  // follows bursts until nb of them have ended
  task automatic watch_bursts(input int nb);
    int bursts;
    int run;
    int gap;
    int trgs;
    int n;
    bursts = 0;
    run = 0;
    gap = 0;
    // first pulse already seen at the trigger
    trgs = 1;
    n = 0;
    while ((bursts < nb || sto_vld) && n < 500) begin
      if (sto_vld) begin
        if (run == 0) begin
          // new burst, phase back at the offset
          assert (bursts == 0 || gap >= cfg_bil) else begin
            err_cnt++;
            $display("burst gap of %0d cycles is shorter than cfg_bil of %0d", gap, cfg_bil);
          end
          ptr_exp = cfg_off;
          bursts++;
        end
        compare_value("sto_dat", tbl_model[ptr_exp[`ASG_CWF +: `ASG_CWM]], sto_dat);
        ptr_exp = next_ptr(ptr_exp);
        run++;
        gap = 0;
      end else begin
        if (run != 0) begin
          compare_value("burst length", cfg_bdl + 1, run);
        end
        run = 0;
        gap++;
      end
      trgs += trg_o;
      @(negedge sto);
      n++;
    end
    if (n >= 500) begin
      tout_cnt++;
      $display("timeout, burst sequence did not end after 500 cycles");
    end
    compare_value("burst length", cfg_bdl + 1, run);
    compare_value("trg_o pulses", nb, trgs);
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    repeat (2) @(negedge sto);
    ctl_rst = 1'b0;

    // random writes, then read-back
    repeat (16) begin
      addr_q.push_back(`ASG_CWM'($random(seed)));
      cpu_access(1'b1, addr_q[$], asg_pkg::sample_t'($random(seed)));
    end
    foreach (addr_q[i]) begin
      cpu_access(1'b0, addr_q[i], '0);
    end

    // ramp table
    for (int i = 0; i < TBL_N; i++) begin
      cpu_access(1'b1, `ASG_CWM'(i), asg_pkg::sample_t'(100 + 3 * i));
    end
    cfg_siz = `ASG_PW'((TBL_N << `ASG_CWF) - 1);

    // whole steps from entry 7, wraps at TBL_N
    cfg_stp = `ASG_PW'(1 << `ASG_CWF);
    cfg_off = `ASG_PW'(7 << `ASG_CWF);
    start_run(4);
    check_stream(3 * TBL_N);
    reset_dut();

    // half step, every entry twice
    cfg_stp = `ASG_PW'(1 << (`ASG_CWF - 1));
    cfg_off = `ASG_PW'((TBL_N - 3) << `ASG_CWF);
    start_run(2);
    check_stream(4 * TBL_N);
    reset_dut();

    // finite bursts with small random lengths
    cfg_ben = 1'b1;
    cfg_stp = `ASG_PW'(1 << `ASG_CWF);
    repeat (2) begin
      cfg_bdl = `ASG_CWM'($unsigned($random(seed)) % 5);
      cfg_bil = 1 + $unsigned($random(seed)) % 5;
      cfg_bnm = 16'(1 + $unsigned($random(seed)) % 4);
      start_run(2);
      watch_bursts(cfg_bnm);
      // trailing gap stays quiet, then a new trigger is taken
      start_run(cfg_bil + 4);
      reset_dut();
    end

    // endless bursts past cfg_bnm until reset
    cfg_inf = 1'b1;
    cfg_bnm = 16'd2;
    start_run(2);
    watch_bursts(cfg_bnm + 2);
    reset_dut();
    start_run(12);
    reset_dut();

    $display("errors: %0d value, %0d timeout, %0d assertion",
             err_cnt, tout_cnt, i_asg_top.i_asg_props.fail_cnt);
    if (err_cnt + tout_cnt + i_asg_top.i_asg_props.fail_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
